//--- src.f
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_cmd_ctrl.sv
hw/uart.sv
tests/tb_uart.sv

//--- Makefile
VERILATOR ?= verilator
FLIST     ?= src.f
TOP       ?= tb_uart
RTL_TOP   ?= uart
BUILD     ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD)

//--- tests/tb_uart.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart import uart_pkg::*;;

  localparam int  BR     = 16;
  localparam real CLK_NS = 8.0;
  localparam real BT     = BR * CLK_NS;                   // one bit-time in ns
  localparam int  N      = 9;
  localparam real WD_NS  = N * 80 * BR * CLK_NS + 10000.0;

  typedef enum logic [1:0] {M_NORMAL, M_BAD_PAR, M_BAD_STOP, M_SILENT} mode_t;

  typedef struct {
    cmd_t        cmd;
    mode_t       mode;
    logic [7:0]  reply;
    bit          rnd;     // addr, wdata and reply come from the lfsr
  } entry_t;

  logic     clk = 1'b0;
  logic     rst_n;
  cmd_t     cmd_in;
  logic     cmd_vld;
  logic     cmd_rdy;
  logic     rx;
  logic     tx;
  logic     read_rdy;
  rd_resp_t read_resp;

  entry_t     tbl [N];
  logic [31:0] lfsr = 32'h3300465c;
  logic [7:0] fr_byte [$];   // frames seen on tx
  logic       fr_par [$];
  logic       fr_stop [$];
  real        fr_t [$];      // start bit times
  bit         peer_read;
  mode_t      peer_mode;
  logic [7:0] peer_reply;

  uart #(
    .BR (BR)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  always #4 clk = ~clk;

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'hA3000000;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v[i] = lfsr_bit();
    return v;
  endfunction

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // idx 0 is the hi byte, 1 the lo byte
  task automatic check_frame(input cmd_t c, input int idx);
    logic [7:0] exp;
    logic [7:0] got;
    logic       par;
    logic       stop;
    exp  = (idx == 0) ? c.b.hi : c.b.lo;
    got  = fr_byte.pop_front();
    par  = fr_par.pop_front();
    stop = fr_stop.pop_front();
    void'(fr_t.pop_front());
    if (got !== exp)
      report_error($sformatf("frame %0d byte %h, expected %h", idx, got, exp));
    if (par !== ^exp)
      report_error($sformatf("frame %0d parity bit %b is not even", idx, par));
    if (stop !== 1'b1)
      report_error($sformatf("frame %0d stop bit low", idx));
  endtask

  task automatic check_read(input rd_resp_t got, input rd_resp_t exp);
    if (got !== exp)
      report_error($sformatf("read data %h err %b, expected %h err %b",
                             got.data, got.err, exp.data, exp.err));
  endtask

  task automatic send_reply(input logic [7:0] d, input mode_t m);
    logic [10:0] fr;
    fr = {m != M_BAD_STOP, (^d) ^ (m == M_BAD_PAR), d, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < 11; i++)
    begin
      rx = fr[i];
      repeat (BR) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  // serial peer, decodes tx at mid-bit
  initial
  begin
    logic [7:0] b;
    real        t0;
    @(posedge rst_n);
    forever
    begin
      @(negedge tx);
      t0 = $realtime;
      #(BT / 2);
      if (tx !== 1'b0)
        report_error("tx start bit not low at its middle");
      for (int i = 0; i < 8; i++)
      begin
        #(BT);
        b[i] = tx;
      end
      #(BT);
      fr_par.push_back(tx);
      #(BT);
      fr_stop.push_back(tx);
      fr_byte.push_back(b);
      fr_t.push_back(t0);
      if (peer_read)
      begin
        peer_read = 1'b0;
        if (peer_mode != M_SILENT)
          fork
            begin  // reply runs beside the decoder
              #(2 * BT);
              send_reply(peer_reply, peer_mode);
            end
          join_none
      end
    end
  end

  initial
  begin
    #(WD_NS);
    $display("timeout: regression did not finish");
    $display("Regression failed");
    $fatal(1);
  end

  task automatic set_entry(input int k, input logic [15:0] w, input mode_t m,
                           input logic [7:0] r, input bit rnd);
    tbl[k].cmd   = w;
    tbl[k].mode  = m;
    tbl[k].reply = r;
    tbl[k].rnd   = rnd;
  endtask

  initial
  begin
    rd_resp_t got;
    rd_resp_t exp;
    real      t_rr;
    bit       fin;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    rst_n     = 1'b0;
    peer_read = 1'b0;
    peer_mode = M_NORMAL;
    peer_reply = '0;

    set_entry(0, 16'h85A5, M_NORMAL,   8'h00, 0);
    set_entry(1, 16'h1200, M_NORMAL,   8'h3C, 0);
    set_entry(2, 16'h2100, M_BAD_PAR,  8'h96, 0);
    set_entry(3, 16'h3300, M_BAD_STOP, 8'h5A, 0);
    set_entry(4, 16'h4400, M_SILENT,   8'h00, 0);
    set_entry(5, 16'h8000, M_NORMAL,   8'h00, 1);
    set_entry(6, 16'h0000, M_NORMAL,   8'h00, 1);
    set_entry(7, 16'h8000, M_NORMAL,   8'h00, 1);
    set_entry(8, 16'h0000, M_BAD_PAR,  8'h00, 1);
    for (int k = 0; k < N; k++)
      if (tbl[k].rnd)
      begin
        tbl[k].cmd.f.addr  = 7'(rand_bits(7));
        tbl[k].cmd.f.wdata = 8'(rand_bits(8));
        tbl[k].reply       = 8'(rand_bits(8));
      end

    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_level("tx after reset", tx, 1'b1);
    check_level("read_rdy after reset", read_rdy, 1'b0);
    check_level("cmd_rdy after reset", cmd_rdy, 1'b1);
    repeat (4 * BR) @(posedge clk);
    #1;
    if (fr_byte.size() != 0)
      report_error("frame seen on tx before the first command");

    for (int k = 0; k < N; k++)
    begin
      peer_mode  = tbl[k].mode;
      peer_reply = tbl[k].reply;
      peer_read  = !tbl[k].cmd.f.wr;
      while (!cmd_rdy)
      begin
        @(posedge clk);
        #1;
      end
      cmd_in  = tbl[k].cmd;
      cmd_vld = 1'b1;   // held until the command ends
      @(posedge clk);
      #1;
      fin = 0;
      while (!fin)
      begin
        if (tbl[k].cmd.f.wr)
        begin
          if (cmd_rdy)
            fin = 1;
          else
            check_level("read_rdy during write", read_rdy, 1'b0);
        end
        else
        begin
          check_level("cmd_rdy during read", cmd_rdy, 1'b0);
          if (read_rdy)
          begin
            got  = read_resp;
            t_rr = $realtime;
            fin  = 1;
          end
        end
        if (!fin)
        begin
          @(posedge clk);
          #1;
        end
      end
      cmd_vld = 1'b0;

      if (tbl[k].cmd.f.wr)
      begin
        if (fr_byte.size() != 2)
          report_error($sformatf("write sent %0d frames, expected 2", fr_byte.size()));
        if (fr_t[1] - fr_t[0] - 11 * BT < GAP_BITS * BT)
          report_error("gap between write frames too short");
        check_frame(tbl[k].cmd, 0);
        check_frame(tbl[k].cmd, 1);
      end
      else
      begin
        @(posedge clk);
        #1;
        check_level("read_rdy after its pulse", read_rdy, 1'b0);
        if (fr_byte.size() != 1)
          report_error($sformatf("read sent %0d frames, expected 1", fr_byte.size()));
        if (tbl[k].mode == M_SILENT)
        begin
          if (t_rr < fr_t[0] + 11 * BT)
            report_error("read timeout came before the tx frame ended");
          if (t_rr - (fr_t[0] + 11 * BT) > (RD_TIMEOUT_BITS + 2) * BT)
            report_error("read timeout came too late");
          exp = '{data: '0, err: 1'b1};
        end
        else
        begin
          exp = '{data: tbl[k].reply, err: tbl[k].mode != M_NORMAL};
        end
        check_frame(tbl[k].cmd, 0);
        check_read(got, exp);
      end
    end

    repeat (20 * BR) @(posedge clk);
    #1;
    if (fr_byte.size() != 0)
      report_error("frame seen on tx after the last command");
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/uart.sv
`timescale 1ns/10ps
`default_nettype none

module uart import uart_pkg::*; #(
  parameter int BR = 434   // clocks per bit
) (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd_in,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  input  logic     rx,
  output logic     tx,
  output logic     read_rdy,
  output rd_resp_t read_resp
);

  tx_req_t tx_req;
  logic    tx_busy;
  rx_res_t rx_res;

  uart_cmd_ctrl #(
    .BR (BR)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_req    (tx_req),
    .tx_busy   (tx_busy),
    .rx_res    (rx_res),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  uart_tx #(
    .BR (BR)
  ) u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx_busy (tx_busy),
    .tx      (tx)
  );

  // receiver runs free, the sequencer picks the reply
  uart_rx #(
    .BR (BR)
  ) u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_res (rx_res)
  );

endmodule

`default_nettype wire

//--- hw/uart_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_ctrl import uart_pkg::*; #(
  parameter int BR = 434
) (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd_in,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  output tx_req_t  tx_req,
  input  logic     tx_busy,
  input  rx_res_t  rx_res,
  output logic     read_rdy,
  output rd_resp_t read_resp
);

  localparam int GAP_CYC = GAP_BITS * BR;
  localparam int TO_CYC  = RD_TIMEOUT_BITS * BR;
  localparam int TW      = $clog2(TO_CYC + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FIRST,
    S_FIRST_WAIT,
    S_GAP,
    S_SECOND,
    S_SECOND_WAIT,
    S_REPLY,
    S_RESPOND
  } state_t;

  state_t   state;
  state_t   state_nx;
  cmd_t     cmd_q;
  rd_resp_t resp_q;
  logic [TW-1:0] tmr;   // gap timer and reply timeout share it
  logic     gap_end;
  logic     to_end;

  assign gap_end = (tmr == TW'(GAP_CYC - 1));
  assign to_end  = (tmr == TW'(TO_CYC - 1));

  assign cmd_rdy   = (state == S_IDLE);
  assign read_rdy  = (state == S_RESPOND);
  assign read_resp = resp_q;

  // byte view drives the line
  assign tx_req = '{start: (state == S_FIRST) || (state == S_SECOND),
                    data:  (state == S_SECOND) ? cmd_q.b.lo : cmd_q.b.hi};

  always_comb
  begin
    state_nx = state;
    case (state)
      S_IDLE:
        if (cmd_vld)
          state_nx = S_FIRST;
      S_FIRST:
        state_nx = S_FIRST_WAIT;
      S_FIRST_WAIT:
        if (!tx_busy)
          state_nx = cmd_q.f.wr ? S_GAP : S_REPLY;
      S_GAP:
        if (gap_end)
          state_nx = S_SECOND;
      S_SECOND:
        state_nx = S_SECOND_WAIT;
      S_SECOND_WAIT:
        if (!tx_busy)
          state_nx = S_IDLE;
      S_REPLY:
        if (rx_res.done || to_end)
          state_nx = S_RESPOND;
      S_RESPOND:
        state_nx = S_IDLE;
      default:
        state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      tmr   <= '0;
    end
    else
    begin
      state <= state_nx;
      if (state == S_GAP || state == S_REPLY)
        tmr <= tmr + 1'b1;
      else
        tmr <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_vld)
      cmd_q <= cmd_in;
    if (state == S_REPLY)
    begin
      if (rx_res.done)
        resp_q <= '{data: rx_res.data, err: rx_res.frame_err};
      else if (to_end)
        resp_q <= '{data: '0, err: 1'b1};  // no start bit in time
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
  parameter int BR = 434
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    rx,
  output rx_res_t rx_res
);

  localparam int CW = (BR > 1) ? $clog2(BR) : 1;

  logic                  rx_s1;
  logic                  rx_s2;
  logic                  rx_d;       // previous synchronized level, for edge detect
  logic                  busy;
  logic [CW-1:0]         br_cnt;     // counts down to the next sample
  logic [3:0]            bit_idx;
  logic [DATA_WIDTH-1:0] shreg;
  logic                  par;
  logic                  par_err;
  logic                  done_q;
  logic                  err_q;

  assign rx_res = '{done: done_q, data: shreg, frame_err: err_q};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      br_cnt  <= '0;
      bit_idx <= '0;
      par     <= 1'b0;
      par_err <= 1'b0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (!busy)
      begin
        if (rx_d && !rx_s2)
        begin
          busy    <= 1'b1;
          br_cnt  <= CW'(BR / 2 - 1);  // first sample at mid start bit
          bit_idx <= '0;
          par     <= 1'b0;
        end
      end
      else if (br_cnt != '0)
      begin
        br_cnt <= br_cnt - 1'b1;
      end
      else
      begin
        br_cnt  <= CW'(BR - 1);
        bit_idx <= bit_idx + 4'd1;
        if (bit_idx == 4'd0)
        begin
          if (rx_s2)
            busy <= 1'b0;  // glitch, not a start bit
        end
        else if (bit_idx <= 4'(DATA_WIDTH))
        begin
          par <= par ^ rx_s2;
        end
        else if (bit_idx == 4'(DATA_WIDTH + 1))
        begin
          par_err <= par ^ rx_s2;
        end
        else
        begin
          busy   <= 1'b0;
          done_q <= 1'b1;
          err_q  <= par_err | ~rx_s2;  // parity or low stop bit
        end
      end
    end
  end

  // data bits shift in lsb first
  always_ff @(posedge clk)
  begin
    if (busy && br_cnt == '0 && bit_idx >= 4'd1 && bit_idx <= 4'(DATA_WIDTH))
      shreg <= {rx_s2, shreg[DATA_WIDTH-1:1]};
  end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
  parameter int BR = 434
) (
  input  logic    clk,
  input  logic    rst_n,
  input  tx_req_t tx_req,
  output logic    tx_busy,
  output logic    tx
);

  localparam int CW = (BR > 1) ? $clog2(BR) : 1;

  logic [CW-1:0]         br_cnt;
  logic [3:0]            bit_idx;
  logic [FRAME_BITS-1:0] shreg;    // stop, parity, data, start; lsb leaves first
  logic                  bit_end;

  assign bit_end = (br_cnt == CW'(BR - 1));

  // line follows the shift register lsb, which is all ones when idle
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      br_cnt  <= '0;
      bit_idx <= '0;
      shreg   <= '1;
    end
    else if (!tx_busy)
    begin
      if (tx_req.start)
      begin
        tx_busy <= 1'b1;
        br_cnt  <= '0;
        bit_idx <= '0;
        shreg   <= {1'b1, ^tx_req.data, tx_req.data, 1'b0};  // even parity
      end
    end
    else if (bit_end)
    begin
      br_cnt <= '0;
      shreg  <= {1'b1, shreg[FRAME_BITS-1:1]};
      if (bit_idx == 4'(FRAME_BITS - 1))
      begin
        tx_busy <= 1'b0;  // last clock of the stop bit
        bit_idx <= '0;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
      end
    end
    else
    begin
      br_cnt <= br_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int CMD_WIDTH       = 16;
  localparam int DATA_WIDTH      = 8;
  localparam int FRAME_BITS      = DATA_WIDTH + 3;  // start, data, parity, stop
  localparam int GAP_BITS        = 16;              // bit-times between write frames
  localparam int RD_TIMEOUT_BITS = 32;              // bit-times to wait for a reply start

  // byte view, in line order
  typedef struct packed {
    logic [CMD_WIDTH-DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0]           lo;
  } cmd_bytes_t;

  // field view
  typedef struct packed {
    logic                            wr;     // 1 = write
    logic [CMD_WIDTH-DATA_WIDTH-2:0] addr;
    logic [DATA_WIDTH-1:0]           wdata;
  } cmd_fields_t;

  typedef union packed {
    cmd_bytes_t  b;
    cmd_fields_t f;
  } cmd_t;

  typedef struct packed {
    logic                  start;
    logic [DATA_WIDTH-1:0] data;
  } tx_req_t;

  typedef struct packed {
    logic                  done;      // one-cycle pulse
    logic [DATA_WIDTH-1:0] data;
    logic                  frame_err;
  } rx_res_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  err;
  } rd_resp_t;

endpackage

`default_nettype wire
